// ==== include/cart_settings.svh ====
// Widths, header addresses and port count for the cartridge loader.
// Address macros are sized to the loader byte address width.
// All loader addresses are byte addresses of 16-bit words, so they are even.
`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

////////////////////
// Loader bus
////////////////////

// Byte address width from the host loader
`define CART_ADDR_W 25

// Loader word width
`define CART_DATA_W 16

// Download index width
`define CART_INDEX_W 8

// Index that marks a cheat code download
`define CART_CODE_INDEX `CART_INDEX_W'(255)

////////////////////
// Memory side
////////////////////

// ROM memory ports fed in parallel
`define CART_MEM_PORTS 2

////////////////////
// Cartridge header
////////////////////

// Region letters live here
`define CART_HDR_REGION_A `CART_ADDR_W'('h1F0)
`define CART_HDR_REGION_B `CART_ADDR_W'('h1F2)

// First address past the header
`define CART_HDR_END `CART_ADDR_W'('h200)

// Product code words and the lookup point
`define CART_ID_FIRST `CART_ADDR_W'('h182)
`define CART_ID_LAST `CART_ADDR_W'('h18A)
`define CART_ID_CHECK `CART_ADDR_W'('h18C)

`endif

// ==== logic/cart_loader_top.sv ====
// Cartridge loading front end: ROM write path, region detect, quirks, cheats.
// The loader must hold off dl_wr while dl_wait is high.
// region_mode 0 uses the file extension index, 1 the header, 2 and 3 do nothing.
`include "cart_settings.svh"

module cart_loader_top (
	input  logic                          clk_sys,
	input  logic                          RESET,
	input  logic                          dl_active,
	input  logic [`CART_INDEX_W-1:0]      dl_index,
	input  logic                          dl_wr,
	input  logic [`CART_ADDR_W-1:0]       dl_addr,
	input  logic [`CART_DATA_W-1:0]       dl_data,
	input  logic [1:0]                    region_mode,
	input  logic [1:0]                    region_priority,
	input  logic [`CART_MEM_PORTS-1:0]    mem_wr_ack,
	output logic                          dl_wait,
	output logic [`CART_ADDR_W-2:0]       mem_wr_addr,
	output logic [`CART_DATA_W-1:0]       mem_wr_data,
	output logic [`CART_MEM_PORTS-1:0]    mem_wr_req,
	output logic [`CART_ADDR_W-1:0]       rom_size,
	output logic [1:0]                    region_req,
	output logic                          region_set,
	output logic                          sram_quirk,
	output logic                          eeprom_quirk,
	output logic                          noram_quirk,
	output logic                          svp_quirk,
	output logic                          fmbusy_quirk,
	output cart_pkg::cheat_code_u         cheat_code,
	output logic                          cheat_strobe,
	output logic                          cheat_reset
);

	// Download stream split
	logic cart_active;
	logic code_active;

	download_sequencer u_seq (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.mem_wr_ack  (mem_wr_ack),
		.cart_active (cart_active),
		.code_active (code_active),
		.dl_wait     (dl_wait),
		.mem_wr_addr (mem_wr_addr),
		.mem_wr_data (mem_wr_data),
		.mem_wr_req  (mem_wr_req),
		.rom_size    (rom_size)
	);

	header_region_detect u_region (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.cart_active     (cart_active),
		.dl_wr           (dl_wr),
		.dl_addr         (dl_addr),
		.dl_data         (dl_data),
		.dl_index        (dl_index),
		.region_mode     (region_mode),
		.region_priority (region_priority),
		.region_req      (region_req),
		.region_set      (region_set)
	);

	cart_quirk_lookup u_quirk (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.cart_active  (cart_active),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.sram_quirk   (sram_quirk),
		.eeprom_quirk (eeprom_quirk),
		.noram_quirk  (noram_quirk),
		.svp_quirk    (svp_quirk),
		.fmbusy_quirk (fmbusy_quirk)
	);

	cheat_code_loader u_cheat (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.code_active  (code_active),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.cheat_code   (cheat_code),
		.cheat_strobe (cheat_strobe),
		.cheat_reset  (cheat_reset)
	);

endmodule

// ==== logic/cart_pkg.sv ====
// Shared types and helpers for the cartridge loader.
// Cheat code fields are big endian 32-bit values as written by the host.
`include "cart_settings.svh"

package cart_pkg;

	////////////////////
	// Cheat code
	////////////////////

	// Field view as used by the cheat engine
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// Word view as written by the loader
	// First index picks the field, second the half (1 = top word)
	typedef union packed {
		logic [0:3][1:0][`CART_DATA_W-1:0] words;
		cheat_fields_t fields;
	} cheat_code_u;

	////////////////////
	// Helpers
	////////////////////

	// Host words arrive with the bytes in the other order
	function automatic logic [`CART_DATA_W-1:0] swap_bytes(input logic [`CART_DATA_W-1:0] w);
		return {w[`CART_DATA_W/2-1:0], w[`CART_DATA_W-1:`CART_DATA_W/2]};
	endfunction

	// Region letter class of one header byte, as {j, u, e}
	// Any other printable from 0 to Z counts as Europe
	function automatic logic [2:0] is_region_char(input logic [7:0] c);
		if (c == "J") begin
			return 3'b100;
		end else if (c == "U") begin
			return 3'b010;
		end else if (c >= "0" && c <= "Z") begin
			return 3'b001;
		end
		return 3'b000;
	endfunction

endpackage

// ==== logic/cart_quirk_lookup.sv ====
// Builds the 8-character product code from the header and flags known titles.
// Flags clear when a new cartridge download starts.
// The table holds only the sram, eeprom, noram, svp and fmbusy classes.
`include "cart_settings.svh"

module cart_quirk_lookup (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    cart_active,
	input  logic                    dl_wr,
	input  logic [`CART_ADDR_W-1:0] dl_addr,
	input  logic [`CART_DATA_W-1:0] dl_data,
	output logic                    sram_quirk,
	output logic                    eeprom_quirk,
	output logic                    noram_quirk,
	output logic                    svp_quirk,
	output logic                    fmbusy_quirk
);

	logic        cart_active_q;
	logic        cart_write;
	logic [63:0] cart_id;
	logic [4:0]  quirk_q;

	// Flag order is {sram, eeprom, noram, svp, fmbusy}
	function automatic logic [4:0] quirk_class(input logic [63:0] id);
		case (id)
			"T-081276", "T-081586", "T-81576 ", "T-81476 ": return 5'b10000;
			"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ": return 5'b01000;
			"T-12046 ":                                     return 5'b01000;
			// Fake RAM check at boot
			"T-113016":                                     return 5'b00100;
			"MK-1229 ", "G-7001  ":                         return 5'b00010;
			"T-35036 ", "T-25073 ", "MK-1137-":             return 5'b00001;
			default:                                        return 5'b00000;
		endcase
	endfunction

	assign cart_write = cart_active & dl_wr;

	////////////////////
	// Product code
	////////////////////

	// Code starts in the high byte of the first word
	always_ff @(posedge clk_sys) begin
		if (cart_write) begin
			if (dl_addr == `CART_ID_FIRST) begin
				cart_id[63:56] <= dl_data[15:8];
			end
			if (dl_addr == `CART_ID_FIRST + `CART_ADDR_W'(2)) begin
				cart_id[55:40] <= cart_pkg::swap_bytes(dl_data);
			end
			if (dl_addr == `CART_ID_FIRST + `CART_ADDR_W'(4)) begin
				cart_id[39:24] <= cart_pkg::swap_bytes(dl_data);
			end
			if (dl_addr == `CART_ID_FIRST + `CART_ADDR_W'(6)) begin
				cart_id[23:8] <= cart_pkg::swap_bytes(dl_data);
			end
			if (dl_addr == `CART_ID_LAST) begin
				cart_id[7:0] <= dl_data[7:0];
			end
		end
	end

	////////////////////
	// Quirk flags
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_active_q <= 1'b0;
			quirk_q       <= '0;
		end else begin
			cart_active_q <= cart_active;
			if (cart_active && !cart_active_q) begin
				quirk_q <= '0;
			end else if (cart_write && dl_addr == `CART_ID_CHECK) begin
				quirk_q <= quirk_q | quirk_class(cart_id);
			end
		end
	end

	assign {sram_quirk, eeprom_quirk, noram_quirk, svp_quirk, fmbusy_quirk} = quirk_q;

endmodule

// ==== logic/cheat_code_loader.sv ====
// Collects 128-bit cheat codes, eight words each, from code downloads.
// The word at offset 14 completes a code; a write at address 0 restarts the list.
`include "cart_settings.svh"

module cheat_code_loader (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    code_active,
	input  logic                    dl_wr,
	input  logic [`CART_ADDR_W-1:0] dl_addr,
	input  logic [`CART_DATA_W-1:0] dl_data,
	output cart_pkg::cheat_code_u   cheat_code,
	output logic                    cheat_strobe,
	output logic                    cheat_reset
);

	logic code_write;

	assign code_write = code_active & dl_wr;

	////////////////////
	// Code assembly
	////////////////////

	// Bits 3..2 pick the field, bit 1 the half, low word first
	always_ff @(posedge clk_sys) begin
		if (code_write) begin
			cheat_code.words[dl_addr[3:2]][dl_addr[1]] <= dl_data;
		end
	end

	////////////////////
	// Strobes
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cheat_strobe <= 1'b0;
			cheat_reset  <= 1'b0;
		end else begin
			// Replace top word is the last one of a code
			cheat_strobe <= code_write && (dl_addr[3:0] == 4'd14);
			cheat_reset  <= code_write && (dl_addr == '0);
		end
	end

endmodule

// ==== logic/download_sequencer.sv ====
// Splits downloads into cartridge and cheat code streams.
// Each cartridge word goes to all memory ports over a toggle req/ack pair.
// Only one write is in flight; dl_wait holds the loader until all ports ack.
`include "cart_settings.svh"

module download_sequencer (
	input  logic                          clk_sys,
	input  logic                          RESET,
	input  logic                          dl_active,
	input  logic [`CART_INDEX_W-1:0]      dl_index,
	input  logic                          dl_wr,
	input  logic [`CART_ADDR_W-1:0]       dl_addr,
	input  logic [`CART_DATA_W-1:0]       dl_data,
	input  logic [`CART_MEM_PORTS-1:0]    mem_wr_ack,
	output logic                          cart_active,
	output logic                          code_active,
	output logic                          dl_wait,
	output logic [`CART_ADDR_W-2:0]       mem_wr_addr,
	output logic [`CART_DATA_W-1:0]       mem_wr_data,
	output logic [`CART_MEM_PORTS-1:0]    mem_wr_req,
	output logic [`CART_ADDR_W-1:0]       rom_size
);

	logic                       code_index;
	logic                       cart_active_q;
	logic                       cart_write;
	logic [`CART_MEM_PORTS-1:0] ack_match;
	logic                       all_acked;

	////////////////////
	// Stream decode
	////////////////////

	assign code_index  = (dl_index == `CART_CODE_INDEX);
	assign cart_active = dl_active & ~code_index;
	assign code_active = dl_active & code_index;
	assign cart_write  = cart_active & dl_wr;

	// Port is idle once its ack caught up with the request
	genvar i;
	generate
		for (i = 0; i < `CART_MEM_PORTS; i++) begin : g_ack
			assign ack_match[i] = (mem_wr_req[i] == mem_wr_ack[i]);
		end
	endgenerate

	assign all_acked = &ack_match;

	////////////////////
	// Handshake
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_wait       <= 1'b0;
			mem_wr_req    <= '0;
			cart_active_q <= 1'b0;
		end else begin
			cart_active_q <= cart_active;
			if (cart_write) begin
				// All ports get the same request
				dl_wait    <= 1'b1;
				mem_wr_req <= ~mem_wr_req;
			end else if (dl_wait && all_acked) begin
				dl_wait <= 1'b0;
			end
		end
	end

	// Address and data stay put while the request is outstanding
	always_ff @(posedge clk_sys) begin
		if (cart_write) begin
			mem_wr_addr <= dl_addr[`CART_ADDR_W-1:1];
			mem_wr_data <= cart_pkg::swap_bytes(dl_data);
		end
		// Last address seen when the cartridge download ends
		if (cart_active_q && !cart_active) begin
			rom_size <= dl_addr;
		end
	end

endmodule

// ==== logic/header_region_detect.sv ====
// Picks the console region from the cartridge header or the file extension.
// Letters are taken from both bytes at 0x1F0 and the low byte at 0x1F2.
// The region request is issued once per download, when the header is complete.
`include "cart_settings.svh"

module header_region_detect (
	input  logic                     clk_sys,
	input  logic                     RESET,
	input  logic                     cart_active,
	input  logic                     dl_wr,
	input  logic [`CART_ADDR_W-1:0]  dl_addr,
	input  logic [`CART_DATA_W-1:0]  dl_data,
	input  logic [`CART_INDEX_W-1:0] dl_index,
	input  logic [1:0]               region_mode,
	input  logic [1:0]               region_priority,
	output logic [1:0]               region_req,
	output logic                     region_set
);

	localparam logic [1:0] REGION_J = 2'd0;
	localparam logic [1:0] REGION_U = 2'd1;
	localparam logic [1:0] REGION_E = 2'd2;

	logic       cart_active_q;
	logic [2:0] hdr_flags;
	logic       hdr_ready;
	logic       hdr_ready_q;
	logic       hdr_edge;
	logic       hdr_j;
	logic       hdr_u;
	logic       hdr_e;
	logic [1:0] region_pick;

	assign {hdr_j, hdr_u, hdr_e} = hdr_flags;

	////////////////////
	// Header scan
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_active_q <= 1'b0;
			hdr_flags     <= '0;
			hdr_ready     <= 1'b0;
		end else begin
			cart_active_q <= cart_active;
			if (cart_active && !cart_active_q) begin
				hdr_flags <= '0;
			end
			if (cart_active_q && !cart_active) begin
				hdr_ready <= 1'b0;
			end
			if (cart_active && dl_wr) begin
				if (dl_addr == `CART_HDR_REGION_A) begin
					hdr_flags <= hdr_flags | cart_pkg::is_region_char(dl_data[15:8])
						| cart_pkg::is_region_char(dl_data[7:0]);
				end
				if (dl_addr == `CART_HDR_REGION_B) begin
					hdr_flags <= hdr_flags | cart_pkg::is_region_char(dl_data[7:0]);
				end
				if (dl_addr == `CART_HDR_END) begin
					hdr_ready <= 1'b1;
				end
			end
		end
	end

	// First present letter in the chosen order, else the order's default
	always_comb begin
		case (region_priority)
			2'd0:    region_pick = hdr_u ? REGION_U : hdr_e ? REGION_E : hdr_j ? REGION_J : REGION_U;
			2'd1:    region_pick = hdr_e ? REGION_E : hdr_u ? REGION_U : hdr_j ? REGION_J : REGION_E;
			2'd2:    region_pick = hdr_u ? REGION_U : hdr_j ? REGION_J : hdr_e ? REGION_E : REGION_U;
			default: region_pick = hdr_j ? REGION_J : hdr_u ? REGION_U : hdr_e ? REGION_E : REGION_J;
		endcase
	end

	////////////////////
	// Region request
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr_ready_q <= 1'b0;
			hdr_edge    <= 1'b0;
			region_req  <= REGION_J;
			region_set  <= 1'b0;
		end else begin
			hdr_ready_q <= hdr_ready;
			hdr_edge    <= hdr_ready & ~hdr_ready_q;
			// Mode 2 and 3 leave the region alone
			if (hdr_edge && !region_mode[1]) begin
				if (region_mode[0]) begin
					region_set <= 1'b1;
					region_req <= region_pick;
				end else begin
					region_set <= |dl_index;
					region_req <= dl_index[7:6];
				end
			end
			if (hdr_ready_q && !hdr_ready) begin
				region_set <= 1'b0;
			end
		end
	end

endmodule

// ==== project.f ====
+incdir+include
logic/cart_pkg.sv
logic/download_sequencer.sv
logic/header_region_detect.sv
logic/cart_quirk_lookup.sv
logic/cheat_code_loader.sv
logic/cart_loader_top.sv
testbench/cart_loader_assertions.sv
testbench/tb_cart_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f project.f \
	--top-module tb_cart_loader \
	-Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/Vtb_cart_loader
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation run failed with status $status"
	exit $status
fi

exit 0

// ==== testbench/cart_input.txt ====
// op a b c d, all hex. 1 start: index mode priority. 2 write: addr data.
// 3 end. 4 rom size. 5 region: req set. 6 quirk {sram,eeprom,noram,svp,fmbusy}.
// 7 cheat: flags address compare replace. 8 cheat reset pulse. 0 stop.
1 0 1 1 0
6 0 0 0 0
2 182 5400 0 0
2 184 302D 0 0
2 186 3138 0 0
2 188 3732 0 0
2 18A 0036 0 0
2 18C 0000 0 0
6 10 0 0 0
2 1F0 4A55 0 0
2 1F2 0020 0 0
2 200 0000 0 0
5 1 1 0 0
3 0 0 0 0
4 200 0 0 0
1 80 0 0 0
6 0 0 0 0
2 182 4D00 0 0
2 184 2D4B 0 0
2 186 3231 0 0
2 188 3932 0 0
2 18A 0020 0 0
2 18C 0000 0 0
6 2 0 0 0
2 200 0000 0 0
5 2 1 0 0
2 204 1234 0 0
3 0 0 0 0
4 204 0 0 0
1 0 1 3 0
6 0 0 0 0
2 1F0 5520 0 0
2 1F2 0045 0 0
2 200 0000 0 0
5 1 1 0 0
3 0 0 0 0
4 200 0 0 0
1 FF 0 0 0
2 0 0001 0 0
2 2 0000 0 0
2 4 2345 0 0
2 6 00FF 0 0
2 8 00AA 0 0
2 A 0000 0 0
2 C 0055 0 0
2 E 0000 0 0
7 00000001 00FF2345 000000AA 00000055
8 0 0 0 0
3 0 0 0 0
0 0 0 0 0

// ==== testbench/cart_loader_assertions.sv ====
// Concurrent checks on the memory handshake and the cheat strobes.
// Bound into cart_loader_top so all ports are top level signals.
`include "cart_settings.svh"

module cart_loader_assertions (
	input logic                       clk_sys,
	input logic                       RESET,
	input logic                       dl_wait,
	input logic [`CART_MEM_PORTS-1:0] mem_wr_req,
	input logic [`CART_MEM_PORTS-1:0] mem_wr_ack,
	input logic                       cheat_strobe,
	input logic                       cheat_reset
);

	timeunit 1ns;
	timeprecision 100ps;

	// Handshake idle out of reset
	reset_idle: assert property (@(posedge clk_sys)
		RESET |=> (!dl_wait && mem_wr_req == '0))
		else $error("dl_wait or a request bit is set after reset");

	// All ports toggle in the same cycle, and only once the last write was acked
	req_together: assert property (@(posedge clk_sys) disable iff (RESET)
		$changed(mem_wr_req) |->
			(mem_wr_req == ~$past(mem_wr_req) && $past(mem_wr_req == mem_wr_ack)))
		else $error("memory request bits changed separately or while a request was pending");

	strobe_single: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat_strobe |=> !cheat_strobe)
		else $error("cheat_strobe lasted more than one cycle");

	reset_single: assert property (@(posedge clk_sys) disable iff (RESET)
		cheat_reset |=> !cheat_reset)
		else $error("cheat_reset lasted more than one cycle");

endmodule

bind cart_loader_top cart_loader_assertions u_checks (
	.clk_sys      (clk_sys),
	.RESET        (RESET),
	.dl_wait      (dl_wait),
	.mem_wr_req   (mem_wr_req),
	.mem_wr_ack   (mem_wr_ack),
	.cheat_strobe (cheat_strobe),
	.cheat_reset  (cheat_reset)
);

// ==== testbench/tb_cart_loader.sv ====
// Script driven testbench for cart_loader_top; run from the project root.
// Memory models ack after 0 to 7 cycles drawn from an LFSR.
// At most 64 cartridge words per download are recorded per port.
`include "cart_settings.svh"

module tb_cart_loader;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int PORTS        = `CART_MEM_PORTS;
	localparam int TIMEOUT      = 200;
	localparam int MAX_WORDS    = 64;
	localparam int SCRIPT_WORDS = 320;

	logic                          clk_sys = 1'b0;
	logic                          RESET;
	logic                          dl_active;
	logic [`CART_INDEX_W-1:0]      dl_index;
	logic                          dl_wr;
	logic [`CART_ADDR_W-1:0]       dl_addr;
	logic [`CART_DATA_W-1:0]       dl_data;
	logic [1:0]                    region_mode;
	logic [1:0]                    region_priority;
	logic [PORTS-1:0]              mem_wr_ack = '0;
	logic                          dl_wait;
	logic [`CART_ADDR_W-2:0]       mem_wr_addr;
	logic [`CART_DATA_W-1:0]       mem_wr_data;
	logic [PORTS-1:0]              mem_wr_req;
	logic [`CART_ADDR_W-1:0]       rom_size;
	logic [1:0]                    region_req;
	logic                          region_set;
	logic                          sram_quirk;
	logic                          eeprom_quirk;
	logic                          noram_quirk;
	logic                          svp_quirk;
	logic                          fmbusy_quirk;
	cart_pkg::cheat_code_u         cheat_code;
	logic                          cheat_strobe;
	logic                          cheat_reset;

	// Script, memory model state and expected words
	logic [31:0]             script [0:SCRIPT_WORDS-1];
	logic [15:0]             lfsr_state = 16'd21640;
	logic                    busy [PORTS];
	logic [2:0]              delay [PORTS];
	logic [`CART_ADDR_W-2:0] got_addr [PORTS][MAX_WORDS];
	logic [`CART_DATA_W-1:0] got_data [PORTS][MAX_WORDS];
	int                      got_count [PORTS];
	logic [`CART_ADDR_W-2:0] exp_addr [$];
	logic [`CART_DATA_W-1:0] exp_data [$];
	int                      strobe_count;
	int                      reset_count;

	always #4 clk_sys = ~clk_sys;

	cart_loader_top uut (
		.clk_sys         (clk_sys),
		.RESET           (RESET),
		.dl_active       (dl_active),
		.dl_index        (dl_index),
		.dl_wr           (dl_wr),
		.dl_addr         (dl_addr),
		.dl_data         (dl_data),
		.region_mode     (region_mode),
		.region_priority (region_priority),
		.mem_wr_ack      (mem_wr_ack),
		.dl_wait         (dl_wait),
		.mem_wr_addr     (mem_wr_addr),
		.mem_wr_data     (mem_wr_data),
		.mem_wr_req      (mem_wr_req),
		.rom_size        (rom_size),
		.region_req      (region_req),
		.region_set      (region_set),
		.sram_quirk      (sram_quirk),
		.eeprom_quirk    (eeprom_quirk),
		.noram_quirk     (noram_quirk),
		.svp_quirk       (svp_quirk),
		.fmbusy_quirk    (fmbusy_quirk),
		.cheat_code      (cheat_code),
		.cheat_strobe    (cheat_strobe),
		.cheat_reset     (cheat_reset)
	);

	////////////////////
	// Helpers
	////////////////////

	task automatic report_fail();
		$display("Simulation failed");
		$fatal(1);
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic check_region(input logic [1:0] req_exp, input logic set_exp);
		if (region_req !== req_exp) begin
			$display("ERR %0t region_req got %0h expected %0h", $time, region_req, req_exp);
			report_fail();
		end
		if (region_set !== set_exp) begin
			$display("ERR %0t region_set got %0h expected %0h", $time, region_set, set_exp);
			report_fail();
		end
	endtask

	task automatic check_quirk(input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp) begin
			$display("ERR %0t quirk flags got %h expected %h", $time, got, exp);
			report_fail();
		end
	endtask

	task automatic check_size(input logic [`CART_ADDR_W-1:0] got,
			input logic [`CART_ADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("ERR %0t rom_size got %h expected %h", $time, got, exp);
			report_fail();
		end
	endtask

	task automatic check_cheat(input cart_pkg::cheat_code_u got,
			input cart_pkg::cheat_code_u exp);
		if (got.fields !== exp.fields) begin
			$display("ERR %0t cheat_code got %h expected %h", $time, got.fields, exp.fields);
			report_fail();
		end
	endtask

	task automatic check_mem_word(input int port, input logic [`CART_ADDR_W-2:0] addr_got,
			input logic [`CART_DATA_W-1:0] data_got, input logic [`CART_ADDR_W-2:0] addr_exp,
			input logic [`CART_DATA_W-1:0] data_exp);
		if (addr_got !== addr_exp) begin
			$display("ERR %0t mem_wr_addr port %0d got %h expected %h",
				$time, port, addr_got, addr_exp);
			report_fail();
		end
		if (data_got !== data_exp) begin
			$display("ERR %0t mem_wr_data port %0d got %h expected %h",
				$time, port, data_got, data_exp);
			report_fail();
		end
	endtask

	task automatic check_all_ports();
		for (int p = 0; p < PORTS; p++) begin
			if (got_count[p] != exp_addr.size()) begin
				$display("Memory port %0d received %0d words but %0d were written",
					p, got_count[p], exp_addr.size());
				report_fail();
			end
			for (int i = 0; i < got_count[p]; i++) begin
				check_mem_word(p, got_addr[p][i], got_data[p][i], exp_addr[i], exp_data[i]);
			end
		end
	endtask

	// One loader write held off while dl_wait is high
	task automatic write_word(input logic [`CART_ADDR_W-1:0] addr,
			input logic [`CART_DATA_W-1:0] data);
		int cycles;
		cycles = 0;
		@(posedge clk_sys);
		while (dl_wait) begin
			cycles++;
			if (cycles > TIMEOUT) begin
				$display("Timed out waiting for dl_wait to fall before a write");
				report_fail();
			end
			@(posedge clk_sys);
		end
		dl_wr   <= 1'b1;
		dl_addr <= addr;
		dl_data <= data;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
	endtask

	task automatic wait_mem_idle();
		int cycles;
		cycles = 0;
		@(posedge clk_sys);
		while (dl_wait || mem_wr_req != mem_wr_ack) begin
			cycles++;
			if (cycles > TIMEOUT) begin
				$display("Timed out waiting for the memory ports to acknowledge");
				report_fail();
			end
			@(posedge clk_sys);
		end
	endtask

	task automatic wait_pulses(input bit want_strobe);
		int cycles;
		cycles = 0;
		while ((want_strobe ? strobe_count : reset_count) == 0) begin
			cycles++;
			if (cycles > TIMEOUT) begin
				$display("Timed out waiting for a cheat strobe or cheat reset pulse");
				report_fail();
			end
			@(posedge clk_sys);
		end
		repeat (2) @(posedge clk_sys);
		if ((want_strobe ? strobe_count : reset_count) != 1) begin
			$display("Expected exactly one cheat pulse but saw more");
			report_fail();
		end
	endtask

	////////////////////
	// Memory models
	////////////////////

	always @(posedge clk_sys) begin
		if (RESET) begin
			mem_wr_ack <= '0;
			for (int p = 0; p < PORTS; p++) begin
				busy[p] = 1'b0;
			end
		end else begin
			for (int p = 0; p < PORTS; p++) begin
				if (!busy[p] && mem_wr_req[p] != mem_wr_ack[p]) begin
					if (got_count[p] < MAX_WORDS) begin
						got_addr[p][got_count[p]] = mem_wr_addr;
						got_data[p][got_count[p]] = mem_wr_data;
					end
					got_count[p]++;
					// One LFSR step per delay bit
					for (int k = 0; k < 3; k++) begin
						lfsr_state = lfsr_next(lfsr_state);
						delay[p] = {delay[p][1:0], lfsr_state[0]};
					end
					busy[p] = 1'b1;
				end else if (busy[p]) begin
					if (delay[p] == 3'd0) begin
						mem_wr_ack[p] <= mem_wr_req[p];
						busy[p] = 1'b0;
					end else begin
						delay[p] = delay[p] - 3'd1;
					end
				end
			end
		end
	end

	// Back-pressure and pulse counters
	always @(posedge clk_sys) begin
		if (!RESET) begin
			if (mem_wr_req != mem_wr_ack && !dl_wait) begin
				$display("dl_wait was low while a memory request was outstanding");
				report_fail();
			end
			if (cheat_strobe) begin
				strobe_count++;
			end
			if (cheat_reset) begin
				reset_count++;
			end
		end
	end

	initial begin
		#1ms;
		$display("Simulation time limit reached");
		report_fail();
	end

	////////////////////
	// Script
	////////////////////

	initial begin
		int pc;
		logic [31:0] op;
		logic [31:0] a;
		logic [31:0] b;
		cart_pkg::cheat_code_u exp_code;

		RESET           = 1'b1;
		dl_active       = 1'b0;
		dl_index        = '0;
		dl_wr           = 1'b0;
		dl_addr         = '0;
		dl_data         = '0;
		region_mode     = 2'd0;
		region_priority = 2'd0;
		strobe_count    = 0;
		reset_count     = 0;
		for (int p = 0; p < PORTS; p++) begin
			got_count[p] = 0;
			delay[p]     = 3'd0;
		end
		$readmemh("testbench/cart_input.txt", script);

		repeat (16) @(posedge clk_sys);
		RESET <= 1'b0;
		repeat (2) @(posedge clk_sys);

		pc = 0;
		op = script[0];
		while (op != 32'd0) begin
			if (pc + 5 > SCRIPT_WORDS) begin
				$display("Stimulus script has no stop line");
				report_fail();
			end
			a = script[pc + 1];
			b = script[pc + 2];
			case (op)
				32'd1: begin
					@(posedge clk_sys);
					dl_active       <= 1'b1;
					dl_index        <= a[7:0];
					region_mode     <= b[1:0];
					region_priority <= script[pc + 3][1:0];
					exp_addr.delete();
					exp_data.delete();
					strobe_count = 0;
					reset_count  = 0;
					for (int p = 0; p < PORTS; p++) begin
						got_count[p] = 0;
					end
					repeat (2) @(posedge clk_sys);
				end
				32'd2: begin
					write_word(a[`CART_ADDR_W-1:0], b[15:0]);
					if (dl_index != 8'hFF) begin
						exp_addr.push_back(a[`CART_ADDR_W-1:1]);
						exp_data.push_back({b[7:0], b[15:8]});
					end
				end
				32'd3: begin
					wait_mem_idle();
					dl_active <= 1'b0;
					repeat (3) @(posedge clk_sys);
					check_all_ports();
				end
				32'd4: check_size(rom_size, a[`CART_ADDR_W-1:0]);
				32'd5: begin
					repeat (4) @(posedge clk_sys);
					check_region(a[1:0], b[0]);
				end
				32'd6: begin
					repeat (2) @(posedge clk_sys);
					check_quirk({sram_quirk, eeprom_quirk, noram_quirk, svp_quirk,
						fmbusy_quirk}, a[4:0]);
				end
				32'd7: begin
					exp_code.fields.flags   = a;
					exp_code.fields.address = b;
					exp_code.fields.compare = script[pc + 3];
					exp_code.fields.replace = script[pc + 4];
					wait_pulses(1'b1);
					check_cheat(cheat_code, exp_code);
				end
				32'd8: wait_pulses(1'b0);
				default: begin
					$display("Unknown opcode %h in the stimulus script", op);
					report_fail();
				end
			endcase
			pc = pc + 5;
			op = script[pc];
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule
